//--- design/rsa_arith_pkg.sv
`default_nettype none

package rsa_arith_pkg;

    // operand width of the whole datapath
    localparam int RSA_WIDTH = 256;

    // bit counter, wide enough to count up to RSA_WIDTH
    localparam int CNT_W = 9;

    // modulus, exponent, message and every intermediate
    typedef logic [RSA_WIDTH-1:0] rsa_word;

    // one extra bit so the multiplier can hold 2^256
    typedef logic [RSA_WIDTH:0] rsa_wide;

endpackage

`default_nettype wire

//--- design/rsa_reg_pkg.sv
`default_nettype none

package rsa_reg_pkg;

    // host bus geometry
    localparam int BUS_DW = 32;
    localparam int BUS_AW = 6;

    // 32-bit words per 256-bit operand
    localparam int WORDS  = 8;
    localparam int WSEL_W = $clog2(WORDS);

    // operand bases, word 0 is the least significant word
    localparam logic [BUS_AW-1:0] ADDR_N    = 6'd0;
    localparam logic [BUS_AW-1:0] ADDR_D    = 6'd8;
    localparam logic [BUS_AW-1:0] ADDR_Y    = 6'd16;
    localparam logic [BUS_AW-1:0] ADDR_RES  = 6'd24;

    // single-word control and status
    localparam logic [BUS_AW-1:0] ADDR_CTRL = 6'd32;
    localparam logic [BUS_AW-1:0] ADDR_STAT = 6'd33;

    localparam int CTRL_START_BIT = 0;
    localparam int STAT_BUSY_BIT  = 0;
    localparam int STAT_DONE_BIT  = 1;

endpackage

`default_nettype wire

//--- design/rsa_op_if.sv
`timescale 1ns/1ps
`default_nettype none

interface rsa_op_if;

    // operands, held by the register block
    rsa_arith_pkg::rsa_word n;
    rsa_arith_pkg::rsa_word d;
    rsa_arith_pkg::rsa_word y;

    // one-cycle launch pulse
    logic start;

    // engine status
    logic busy;
    logic done;

    // y^d mod N, stable from done until the next start
    rsa_arith_pkg::rsa_word result;

    modport cfg (
        output n, d, y, start,
        input  busy, done, result
    );

    modport engine (
        input  n, d, y, start,
        output busy, done, result
    );

endinterface

`default_nettype wire

//--- design/modulo_product.sv
`timescale 1ns/1ps
`default_nettype none

module modulo_product (
    input  logic                   i_clk,
    input  logic                   i_rst,
    input  logic                   i_start,
    input  rsa_arith_pkg::rsa_word i_n,
    input  rsa_arith_pkg::rsa_wide i_a,
    input  rsa_arith_pkg::rsa_word i_b,
    output rsa_arith_pkg::rsa_word o_p,
    output logic                   o_done
);

    logic                            busy;
    logic [rsa_arith_pkg::CNT_W-1:0] cnt;
    logic                            step;
    logic                            a_bit;
    rsa_arith_pkg::rsa_word          t;
    rsa_arith_pkg::rsa_word          m;
    rsa_arith_pkg::rsa_word          a_sh;
    rsa_arith_pkg::rsa_word          t_src;
    rsa_arith_pkg::rsa_word          m_src;
    rsa_arith_pkg::rsa_word          t_dbl;
    rsa_arith_pkg::rsa_word          m_add;

    // x + y mod n for x, y < n, the carry bit keeps the compare exact
    function automatic rsa_arith_pkg::rsa_word mod_add(input rsa_arith_pkg::rsa_word x,
                                                       input rsa_arith_pkg::rsa_word y,
                                                       input rsa_arith_pkg::rsa_word n);
        rsa_arith_pkg::rsa_wide s;
        s = {1'b0, x} + {1'b0, y};
        if (s >= {1'b0, n}) begin
            s = s - {1'b0, n};
        end
        return s[rsa_arith_pkg::RSA_WIDTH-1:0];
    endfunction

    // bit 0 of a is handled in the start cycle itself
    always_comb begin
        t_src = busy ? t : i_b;
        m_src = busy ? m : '0;
        a_bit = busy ? a_sh[0] : i_a[0];
        t_dbl = mod_add(t_src, t_src, i_n);
        m_add = a_bit ? mod_add(m_src, t_src, i_n) : m_src;
    end

    assign step = busy || i_start;

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            busy   <= 1'b0;
            cnt    <= '0;
            o_done <= 1'b0;
        end else begin
            o_done <= 1'b0;
            if (!busy && i_start) begin
                busy <= 1'b1;
                cnt  <= '0;
            end else if (busy) begin
                cnt <= cnt + 1'b1;
                // 256 more steps cover bits 1..256
                if (cnt == rsa_arith_pkg::RSA_WIDTH - 1) begin
                    busy   <= 1'b0;
                    o_done <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (step) begin
            t    <= t_dbl;
            m    <= m_add;
            a_sh <= busy ? (a_sh >> 1) : i_a[rsa_arith_pkg::RSA_WIDTH:1];
        end
    end

    assign o_p = m;

    p_below_n: assert property (@(posedge i_clk) disable iff (i_rst)
        o_done |=> (o_p < i_n));

endmodule

`default_nettype wire

//--- design/montgomery_mul.sv
`timescale 1ns/1ps
`default_nettype none

module montgomery_mul (
    input  logic                   i_clk,
    input  logic                   i_rst,
    input  logic                   i_start,
    input  rsa_arith_pkg::rsa_word i_n,
    input  rsa_arith_pkg::rsa_word i_a,
    input  rsa_arith_pkg::rsa_word i_b,
    output rsa_arith_pkg::rsa_word o_p,
    output logic                   o_done
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_ITER,
        S_SUB
    } state_t;

    state_t                            state;
    logic [rsa_arith_pkg::CNT_W-1:0]   cnt;
    logic                              step;
    logic                              a_bit;
    rsa_arith_pkg::rsa_word            a_sh;
    rsa_arith_pkg::rsa_wide            acc;
    rsa_arith_pkg::rsa_wide            acc_src;
    // acc < 2N, plus b, plus N, still below 2^258
    logic [rsa_arith_pkg::RSA_WIDTH+1:0] sum;

    // first iteration runs in the start cycle
    assign step = (state == S_ITER) || (state == S_IDLE && i_start);

    always_comb begin
        acc_src = (state == S_IDLE) ? '0 : acc;
        a_bit   = (state == S_IDLE) ? i_a[0] : a_sh[0];
        sum     = {1'b0, acc_src} + (a_bit ? {2'b00, i_b} : '0);
        // make the sum even so the halving is exact
        if (sum[0]) begin
            sum = sum + {2'b00, i_n};
        end
    end

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            state  <= S_IDLE;
            cnt    <= '0;
            o_done <= 1'b0;
        end else begin
            o_done <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (i_start) begin
                        state <= S_ITER;
                        cnt   <= '0;
                    end
                end
                S_ITER: begin
                    cnt <= cnt + 1'b1;
                    // bits 1..255 take 255 cycles
                    if (cnt == rsa_arith_pkg::RSA_WIDTH - 2) begin
                        state <= S_SUB;
                    end
                end
                S_SUB: begin
                    state  <= S_IDLE;
                    o_done <= 1'b1;
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (step) begin
            acc  <= sum[rsa_arith_pkg::RSA_WIDTH+1:1];
            a_sh <= (state == S_IDLE) ? (i_a >> 1) : (a_sh >> 1);
        end else if (state == S_SUB && acc >= {1'b0, i_n}) begin
            // one conditional subtraction brings acc below N
            acc <= acc - {1'b0, i_n};
        end
    end

    assign o_p = acc[rsa_arith_pkg::RSA_WIDTH-1:0];

    no_restart: assert property (@(posedge i_clk) disable iff (i_rst)
        (state != S_IDLE) |-> !i_start);

endmodule

`default_nettype wire

//--- design/modexp_engine.sv
`timescale 1ns/1ps
`default_nettype none

module modexp_engine (
    input  logic      i_clk,
    input  logic      i_rst,
    rsa_op_if.engine  op
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_PRE_T,
        S_PRE_M,
        S_MUL,
        S_SQR,
        S_FIN
    } state_t;

    state_t                          state;
    logic                            kick;
    logic                            busy_r;
    logic                            done_r;
    logic [rsa_arith_pkg::CNT_W-1:0] cnt;
    rsa_arith_pkg::rsa_word          n_r;
    rsa_arith_pkg::rsa_word          d_sh;
    rsa_arith_pkg::rsa_word          y_r;
    rsa_arith_pkg::rsa_word          t_r;
    rsa_arith_pkg::rsa_word          m_r;

    logic                            prod_start;
    logic                            prod_done;
    rsa_arith_pkg::rsa_wide          prod_a;
    rsa_arith_pkg::rsa_word          prod_b;
    rsa_arith_pkg::rsa_word          prod_p;
    logic                            mont_start;
    logic                            mont_done;
    rsa_arith_pkg::rsa_word          mont_a;
    rsa_arith_pkg::rsa_word          mont_b;
    rsa_arith_pkg::rsa_word          mont_p;

    // domain entry, y*R mod N then R mod N
    assign prod_a     = rsa_arith_pkg::rsa_wide'(1) << rsa_arith_pkg::RSA_WIDTH;
    assign prod_b     = (state == S_PRE_T) ? y_r : rsa_arith_pkg::rsa_word'(1);
    assign prod_start = kick && (state == S_PRE_T || state == S_PRE_M);

    // shared unit, multiply m*t, square t*t, exit m*1
    assign mont_a     = (state == S_SQR) ? t_r : m_r;
    assign mont_b     = (state == S_FIN) ? rsa_arith_pkg::rsa_word'(1) : t_r;
    assign mont_start = kick && (state == S_MUL || state == S_SQR || state == S_FIN);

    modulo_product u_prod (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_start (prod_start),
        .i_n     (n_r),
        .i_a     (prod_a),
        .i_b     (prod_b),
        .o_p     (prod_p),
        .o_done  (prod_done)
    );

    montgomery_mul u_mont (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_start (mont_start),
        .i_n     (n_r),
        .i_a     (mont_a),
        .i_b     (mont_b),
        .o_p     (mont_p),
        .o_done  (mont_done)
    );

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            state  <= S_IDLE;
            kick   <= 1'b0;
            busy_r <= 1'b0;
            done_r <= 1'b0;
            cnt    <= '0;
        end else begin
            kick   <= 1'b0;
            done_r <= 1'b0;
            // busy stays up through the done cycle
            if (done_r) begin
                busy_r <= 1'b0;
            end
            case (state)
                S_IDLE: begin
                    if (op.start) begin
                        state  <= S_PRE_T;
                        kick   <= 1'b1;
                        busy_r <= 1'b1;
                        cnt    <= '0;
                    end
                end
                S_PRE_T: begin
                    if (prod_done) begin
                        state <= S_PRE_M;
                        kick  <= 1'b1;
                    end
                end
                S_PRE_M: begin
                    if (prod_done) begin
                        state <= d_sh[0] ? S_MUL : S_SQR;
                        kick  <= 1'b1;
                    end
                end
                S_MUL: begin
                    if (mont_done) begin
                        state <= S_SQR;
                        kick  <= 1'b1;
                    end
                end
                S_SQR: begin
                    if (mont_done) begin
                        kick <= 1'b1;
                        cnt  <= cnt + 1'b1;
                        if (cnt == rsa_arith_pkg::RSA_WIDTH - 1) begin
                            state <= S_FIN;
                        end else begin
                            // d_sh[1] is the next exponent bit before the shift
                            state <= d_sh[1] ? S_MUL : S_SQR;
                        end
                    end
                end
                S_FIN: begin
                    if (mont_done) begin
                        state  <= S_IDLE;
                        done_r <= 1'b1;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (state == S_IDLE && op.start) begin
            n_r  <= op.n;
            d_sh <= op.d;
            y_r  <= op.y;
        end
        if (prod_done) begin
            if (state == S_PRE_T) begin
                t_r <= prod_p;
            end else begin
                m_r <= prod_p;
            end
        end
        if (mont_done) begin
            if (state == S_SQR) begin
                t_r  <= mont_p;
                d_sh <= d_sh >> 1;
            end else begin
                m_r <= mont_p;
            end
        end
    end

    // m_r holds the plain result after the exit multiply
    assign op.result = m_r;
    assign op.busy   = busy_r;
    assign op.done   = done_r;

    done_in_busy: assert property (@(posedge i_clk) disable iff (i_rst)
        op.done |-> op.busy);

endmodule

`default_nettype wire

//--- design/rsa_cfg_regs.sv
`timescale 1ns/1ps
`default_nettype none

module rsa_cfg_regs (
    input  logic                           i_clk,
    input  logic                           i_rst,
    input  logic                           i_req,
    input  logic                           i_we,
    input  logic [rsa_reg_pkg::BUS_AW-1:0] i_addr,
    input  logic [rsa_reg_pkg::BUS_DW-1:0] i_wdata,
    output logic                           o_ack,
    output logic [rsa_reg_pkg::BUS_DW-1:0] o_rdata,
    rsa_op_if.cfg                          op
);

    rsa_arith_pkg::rsa_word         n_r;
    rsa_arith_pkg::rsa_word         d_r;
    rsa_arith_pkg::rsa_word         y_r;
    rsa_arith_pkg::rsa_word         res_r;
    logic                           start_r;
    logic                           done_bit;
    logic                           access;
    logic                           idle;
    logic [rsa_reg_pkg::WSEL_W-1:0] wsel;
    logic [rsa_reg_pkg::BUS_AW-1:0] base;
    logic [rsa_reg_pkg::BUS_DW-1:0] rd_word;

    // a new transaction is a request not yet acknowledged
    assign access = i_req && !o_ack;
    assign idle   = !op.busy;

    // word within an operand and the operand base address
    assign wsel = i_addr[rsa_reg_pkg::WSEL_W-1:0];
    assign base = {i_addr[rsa_reg_pkg::BUS_AW-1:rsa_reg_pkg::WSEL_W],
                   {rsa_reg_pkg::WSEL_W{1'b0}}};

    always_comb begin
        rd_word = '0;
        case (base)
            rsa_reg_pkg::ADDR_N:   rd_word = n_r[wsel*rsa_reg_pkg::BUS_DW +: rsa_reg_pkg::BUS_DW];
            rsa_reg_pkg::ADDR_D:   rd_word = d_r[wsel*rsa_reg_pkg::BUS_DW +: rsa_reg_pkg::BUS_DW];
            rsa_reg_pkg::ADDR_Y:   rd_word = y_r[wsel*rsa_reg_pkg::BUS_DW +: rsa_reg_pkg::BUS_DW];
            rsa_reg_pkg::ADDR_RES: rd_word = res_r[wsel*rsa_reg_pkg::BUS_DW +: rsa_reg_pkg::BUS_DW];
            default: begin
                // control reads back zero since start is a pulse
                if (i_addr == rsa_reg_pkg::ADDR_STAT) begin
                    rd_word[rsa_reg_pkg::STAT_BUSY_BIT] = op.busy;
                    rd_word[rsa_reg_pkg::STAT_DONE_BIT] = done_bit;
                end
            end
        endcase
    end

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            o_ack    <= 1'b0;
            o_rdata  <= '0;
            n_r      <= '0;
            d_r      <= '0;
            y_r      <= '0;
            res_r    <= '0;
            start_r  <= 1'b0;
            done_bit <= 1'b0;
        end else begin
            // ack follows req one cycle later in both directions
            o_ack   <= i_req;
            start_r <= 1'b0;
            if (start_r) begin
                done_bit <= 1'b0;
            end else if (op.done) begin
                done_bit <= 1'b1;
            end
            if (op.done) begin
                res_r <= op.result;
            end
            if (access) begin
                o_rdata <= rd_word;
                // operand and start writes only land while the engine is idle
                if (i_we && idle) begin
                    case (base)
                        rsa_reg_pkg::ADDR_N:
                            n_r[wsel*rsa_reg_pkg::BUS_DW +: rsa_reg_pkg::BUS_DW] <= i_wdata;
                        rsa_reg_pkg::ADDR_D:
                            d_r[wsel*rsa_reg_pkg::BUS_DW +: rsa_reg_pkg::BUS_DW] <= i_wdata;
                        rsa_reg_pkg::ADDR_Y:
                            y_r[wsel*rsa_reg_pkg::BUS_DW +: rsa_reg_pkg::BUS_DW] <= i_wdata;
                        default:
                            start_r <= (i_addr == rsa_reg_pkg::ADDR_CTRL) &&
                                       i_wdata[rsa_reg_pkg::CTRL_START_BIT];
                    endcase
                end
            end
        end
    end

    assign op.n     = n_r;
    assign op.d     = d_r;
    assign op.y     = y_r;
    assign op.start = start_r;

    ack_needs_req: assert property (@(posedge i_clk) disable iff (i_rst)
        (!i_req && !o_ack) |=> !o_ack);

endmodule

`default_nettype wire

//--- design/rsa_core.sv
`timescale 1ns/1ps
`default_nettype none

module rsa_core (
    input  logic                           i_clk,
    input  logic                           i_rst,
    input  logic                           i_req,
    input  logic                           i_we,
    input  logic [rsa_reg_pkg::BUS_AW-1:0] i_addr,
    input  logic [rsa_reg_pkg::BUS_DW-1:0] i_wdata,
    output logic                           o_ack,
    output logic [rsa_reg_pkg::BUS_DW-1:0] o_rdata
);

    // operands, start, status and result between registers and engine
    rsa_op_if op_bus ();

    rsa_cfg_regs u_cfg_regs (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_req   (i_req),
        .i_we    (i_we),
        .i_addr  (i_addr),
        .i_wdata (i_wdata),
        .o_ack   (o_ack),
        .o_rdata (o_rdata),
        .op      (op_bus)
    );

    modexp_engine u_engine (
        .i_clk (i_clk),
        .i_rst (i_rst),
        .op    (op_bus)
    );

endmodule

`default_nettype wire

//--- tb/rsa_bus_tasks.svh
`ifndef RSA_BUS_TASKS_SVH
`define RSA_BUS_TASKS_SVH

// one four-phase transfer, inputs change only on the falling edge
task automatic bus_transfer(input  logic                           is_write,
                            input  logic [rsa_reg_pkg::BUS_AW-1:0] a,
                            input  logic [rsa_reg_pkg::BUS_DW-1:0] data_in,
                            output logic [rsa_reg_pkg::BUS_DW-1:0] data_out);
    int cycles;
    @(negedge clk);
    assert (!ack) else begin
        report_problem("o_ack was still high when a new request started");
    end
    req    = 1'b1;
    we     = is_write;
    addr   = a;
    wdata  = data_in;
    cycles = 0;
    while (!ack && cycles < BUS_TIMEOUT) begin
        @(negedge clk);
        cycles++;
    end
    if (!ack) begin
        report_problem("timeout waiting for o_ack to rise");
    end
    // read data is valid while ack is high
    data_out = rdata;
    req      = 1'b0;
    we       = 1'b0;
    cycles   = 0;
    while (ack && cycles < BUS_TIMEOUT) begin
        @(negedge clk);
        cycles++;
    end
    if (ack) begin
        report_problem("timeout waiting for o_ack to fall");
    end
endtask

task automatic bus_write(input logic [rsa_reg_pkg::BUS_AW-1:0] a,
                         input logic [rsa_reg_pkg::BUS_DW-1:0] data);
    logic [rsa_reg_pkg::BUS_DW-1:0] unused;
    bus_transfer(1'b1, a, data, unused);
endtask

task automatic bus_read(input  logic [rsa_reg_pkg::BUS_AW-1:0] a,
                        output logic [rsa_reg_pkg::BUS_DW-1:0] data);
    bus_transfer(1'b0, a, '0, data);
endtask

// word 0 goes to the base address
task automatic write_operand(input logic [rsa_reg_pkg::BUS_AW-1:0] base,
                             input logic [255:0]                   value);
    for (int w = 0; w < rsa_reg_pkg::WORDS; w++) begin
        bus_write(base + w[5:0], value[w*32 +: 32]);
    end
endtask

task automatic read_operand(input  logic [rsa_reg_pkg::BUS_AW-1:0] base,
                            output logic [255:0]                   value);
    logic [rsa_reg_pkg::BUS_DW-1:0] word;
    for (int w = 0; w < rsa_reg_pkg::WORDS; w++) begin
        bus_read(base + w[5:0], word);
        value[w*32 +: 32] = word;
    end
endtask

// square-and-multiply on 512-bit intermediates, exponent lsb first
task automatic modexp_model(input  logic [255:0] mod_n,
                            input  logic [255:0] exp_d,
                            input  logic [255:0] msg_y,
                            output logic [255:0] res);
    logic [511:0] modulus;
    logic [511:0] acc;
    logic [511:0] base;
    modulus = {256'd0, mod_n};
    acc     = 512'd1 % modulus;
    base    = {256'd0, msg_y} % modulus;
    for (int i = 0; i < 256; i++) begin
        if (exp_d[i]) begin
            acc = (acc * base) % modulus;
        end
        base = (base * base) % modulus;
    end
    res = acc[255:0];
endtask

`endif

//--- tb/tb_rsa_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_rsa_core;

    localparam int BUS_TIMEOUT = 16;
    localparam int POLL_LIMIT  = 100000;

    logic                           clk = 1'b0;
    logic                           rst;
    logic                           req;
    logic                           we;
    logic [rsa_reg_pkg::BUS_AW-1:0] addr;
    logic [rsa_reg_pkg::BUS_DW-1:0] wdata;
    logic                           ack;
    logic [rsa_reg_pkg::BUS_DW-1:0] rdata;
    logic                           req_seen = 1'b0;
    logic                           ack_prev = 1'b0;

    rsa_core i_rsa_core (
        .i_clk   (clk),
        .i_rst   (rst),
        .i_req   (req),
        .i_we    (we),
        .i_addr  (addr),
        .i_wdata (wdata),
        .o_ack   (ack),
        .o_rdata (rdata)
    );

    always #50 clk = ~clk;

    task automatic stop_on_failure();
        $display("Result: FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic report_problem(input string msg);
        $display("Error at %0t: %s", $time, msg);
        stop_on_failure();
    endtask

    task automatic check_value(input string name, input logic [255:0] exp,
                               input logic [255:0] act);
        assert (act === exp) else begin
            $display("Fail at %0t: %s expected %0h actual %0h", $time, name, exp, act);
            stop_on_failure();
        end
    endtask

    `include "rsa_bus_tasks.svh"

    function automatic logic [255:0] rand_word();
        logic [255:0] v;
        for (int w = 0; w < 8; w++) begin
            v[w*32 +: 32] = $urandom;
        end
        return v;
    endfunction

    // odd modulus with the top bit set
    function automatic logic [255:0] rand_modulus();
        logic [255:0] v;
        v      = rand_word();
        v[255] = 1'b1;
        v[0]   = 1'b1;
        return v;
    endfunction

    // wait until the status busy bit clears
    task automatic wait_idle(output logic [31:0] stat);
        int polls;
        polls = 0;
        bus_read(rsa_reg_pkg::ADDR_STAT, stat);
        while (stat[rsa_reg_pkg::STAT_BUSY_BIT] && polls < POLL_LIMIT) begin
            bus_read(rsa_reg_pkg::ADDR_STAT, stat);
            polls++;
        end
        if (stat[rsa_reg_pkg::STAT_BUSY_BIT]) begin
            report_problem("engine still busy after the poll limit");
        end
    endtask

    task automatic run_modexp(input logic [255:0] n, input logic [255:0] d,
                              input logic [255:0] y, output logic [255:0] res,
                              output logic [31:0] stat);
        write_operand(rsa_reg_pkg::ADDR_N, n);
        write_operand(rsa_reg_pkg::ADDR_D, d);
        write_operand(rsa_reg_pkg::ADDR_Y, y);
        bus_write(rsa_reg_pkg::ADDR_CTRL, 32'd1 << rsa_reg_pkg::CTRL_START_BIT);
        wait_idle(stat);
        read_operand(rsa_reg_pkg::ADDR_RES, res);
    endtask

    // ack must follow req sampled at the previous rising edge
    always @(posedge clk) begin
        req_seen <= req;
    end

    always @(negedge clk) begin
        if (ack && !ack_prev) begin
            assert (req_seen) else begin
                report_problem("o_ack rose without a pending i_req");
            end
        end
        if (!ack && ack_prev) begin
            assert (!req_seen) else begin
                report_problem("o_ack fell while i_req was still high");
            end
        end
        ack_prev <= ack;
    end

    initial begin : main_seq
        logic [255:0] n;
        logic [255:0] d;
        logic [255:0] y;
        logic [255:0] expect_r;
        logic [255:0] got;
        logic [31:0]  stat;
        logic [31:0]  word;
        int           seed;

        seed  = $urandom(32'ha05f_6028);
        rst   = 1'b1;
        req   = 1'b0;
        we    = 1'b0;
        addr  = '0;
        wdata = '0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // state right after reset
        check_value("o_ack", 0, ack);
        bus_read(rsa_reg_pkg::ADDR_STAT, stat);
        check_value("STAT", 0, stat);
        read_operand(rsa_reg_pkg::ADDR_N, got);
        check_value("N", 0, got);
        read_operand(rsa_reg_pkg::ADDR_D, got);
        check_value("D", 0, got);
        read_operand(rsa_reg_pkg::ADDR_Y, got);
        check_value("Y", 0, got);
        read_operand(rsa_reg_pkg::ADDR_RES, got);
        check_value("RES", 0, got);

        // operand readback and unmapped space
        n = rand_word();
        d = rand_word();
        y = rand_word();
        write_operand(rsa_reg_pkg::ADDR_N, n);
        write_operand(rsa_reg_pkg::ADDR_D, d);
        write_operand(rsa_reg_pkg::ADDR_Y, y);
        read_operand(rsa_reg_pkg::ADDR_N, got);
        check_value("N", n, got);
        read_operand(rsa_reg_pkg::ADDR_D, got);
        check_value("D", d, got);
        read_operand(rsa_reg_pkg::ADDR_Y, got);
        check_value("Y", y, got);
        bus_write(6'd40, $urandom);
        bus_read(6'd40, word);
        check_value("rdata at 40", 0, word);
        bus_read(6'd63, word);
        check_value("rdata at 63", 0, word);

        // random keys and messages
        for (int k = 0; k < 4; k++) begin
            n = rand_modulus();
            d = rand_word();
            y = rand_word() % n;
            run_modexp(n, d, y, got, stat);
            modexp_model(n, d, y, expect_r);
            check_value("RES", expect_r, got);
            check_value("STAT_DONE", 1, stat[rsa_reg_pkg::STAT_DONE_BIT]);
        end

        // edge exponents and a zero message
        n = rand_modulus();
        y = rand_word() % n;
        run_modexp(n, 256'd0, y, got, stat);
        check_value("RES with d=0", 1, got);
        run_modexp(n, 256'd1, y, got, stat);
        check_value("RES with d=1", y, got);
        d    = rand_word();
        d[0] = 1'b1;
        run_modexp(n, d, 256'd0, got, stat);
        check_value("RES with y=0", 0, got);

        // writes during a run are dropped and a new start clears done
        n = rand_modulus();
        d = rand_word();
        y = rand_word() % n;
        write_operand(rsa_reg_pkg::ADDR_N, n);
        write_operand(rsa_reg_pkg::ADDR_D, d);
        write_operand(rsa_reg_pkg::ADDR_Y, y);
        bus_read(rsa_reg_pkg::ADDR_STAT, stat);
        check_value("STAT_DONE", 1, stat[rsa_reg_pkg::STAT_DONE_BIT]);
        bus_write(rsa_reg_pkg::ADDR_CTRL, 32'd1 << rsa_reg_pkg::CTRL_START_BIT);
        bus_read(rsa_reg_pkg::ADDR_STAT, stat);
        check_value("STAT_DONE", 0, stat[rsa_reg_pkg::STAT_DONE_BIT]);
        check_value("STAT_BUSY", 1, stat[rsa_reg_pkg::STAT_BUSY_BIT]);
        bus_write(rsa_reg_pkg::ADDR_Y + 6'd3, ~y[127:96]);
        bus_write(rsa_reg_pkg::ADDR_CTRL, 32'd1 << rsa_reg_pkg::CTRL_START_BIT);
        wait_idle(stat);
        read_operand(rsa_reg_pkg::ADDR_RES, got);
        modexp_model(n, d, y, expect_r);
        check_value("RES", expect_r, got);
        check_value("STAT_DONE", 1, stat[rsa_reg_pkg::STAT_DONE_BIT]);
        read_operand(rsa_reg_pkg::ADDR_Y, got);
        check_value("Y", y, got);

        $display("Result: PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- sources.f
+incdir+tb
design/rsa_arith_pkg.sv
design/rsa_reg_pkg.sv
design/rsa_op_if.sv
design/modulo_product.sv
design/montgomery_mul.sv
design/modexp_engine.sv
design/rsa_cfg_regs.sv
design/rsa_core.sv
tb/tb_rsa_core.sv
